// ==== files.f ====
capture_pkg.sv
source_fsm.sv
raw_timing_counter.sv
window_mapper.sv
pixel_assembler.sv
bar_pattern.sv
frame_stats.sv
capture_top.sv
capture_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = capture_tb
FILELIST = files.f
FLAGS    = --binary --timing -j 0

SOURCES  = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir

// ==== capture_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_tb;
    import capture_pkg::*;

    localparam int IDLE_CLOCKS = 200;
    localparam int ROWS        = 9;
    // VGA window from the mode table
    localparam int VGA_HSTART  = 265;
    localparam int VGA_VSTART  = 40;
    localparam int VGA_HEIGHT  = 480;
    // drive-loop index of the first word of column 0
    localparam int FIRST_WORD  = VGA_HSTART + 2;
    localparam int BOUND_LINE  = 100;
    localparam int BOUND_FIRST = 100;
    localparam int BOUND_LAST  = 300;

    localparam int PAT_ZERO   = 0;
    localparam int PAT_PIXEL  = 1;
    localparam int PAT_BARS   = 2;
    localparam int PAT_DIAG   = 3;
    localparam int PAT_BOUNDS = 4;

    localparam int CHK_NONE  = 0;
    localparam int CHK_PIXEL = 1;
    localparam int CHK_BARS  = 2;

    typedef struct {
        int          lines;
        int          len;
        bit          doubler;
        bit          gen_video;
        int          pattern;
        int          frames;
        video_mode_t exp_mode;
        bit          exp_resync;
    } row_t;

    logic        clock;
    logic        reset;
    logic [11:0] data;
    logic        hsync_n;
    logic        vsync_n;
    logic        line_doubler;
    logic        generate_video;
    logic        generate_timing;
    logic        nonblack_reset;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic [11:0] counter_x;
    logic [11:0] counter_y;
    video_mode_t mode;
    logic        resync;
    logic [23:0] timing_info;
    logic [23:0] pin_ok;
    logic [23:0] color_explorer;
    logic [11:0] non_black_first;
    logic [11:0] non_black_last;
    logic        force_generate;

    row_t        rows [ROWS];
    logic [11:0] diag_words [8];
    int          errors;
    int          checks;
    int          cycles = 0;
    int          limit;

    capture_top #(
        .IDLE_LIMIT(IDLE_CLOCKS)
    ) DUT (
        .clock(clock), .reset(reset), .data(data), .hsync_n(hsync_n),
        .vsync_n(vsync_n), .line_doubler(line_doubler),
        .generate_video(generate_video), .generate_timing(generate_timing),
        .nonblack_reset(nonblack_reset), .red(red), .green(green), .blue(blue),
        .counter_x(counter_x), .counter_y(counter_y), .mode(mode), .resync(resync),
        .timing_info(timing_info), .pin_ok(pin_ok), .color_explorer(color_explorer),
        .non_black_first(non_black_first), .non_black_last(non_black_last),
        .force_generate(force_generate)
    );

    always #4 clock = ~clock;

    // guard against a hung run
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run went past %0d clock cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // first word gives red and green high, second word green low and blue
    function automatic logic [23:0] split_word(input logic [11:0] w);
        return {w[11:4], w[3:0], w[11:8], w[7:0]};
    endfunction

    function automatic logic [23:0] bar_color(input int bar);
        case (bar)
            0:       return 24'hFF0000;
            1:       return 24'h00FF00;
            2:       return 24'h0000FF;
            3:       return 24'hFFFFFF;
            5:       return 24'h00FFFF;
            6:       return 24'hFFFF00;
            7:       return 24'hFF00FF;
            default: return 24'h000000;
        endcase
    endfunction

    task automatic drive_line(input int len, input bit vs, input logic [11:0] word,
                              input int kind, input logic [23:0] exp_rgb,
                              input int exp_y, input bit bounded);
        int cx;
        int col;
        int pos;
        for (int c = 0; c < len; c++) begin
            @(posedge clock);
            hsync_n <= (c >= 4);
            vsync_n <= !(vs && c < 4);
            if (bounded) begin
                col = (c - FIRST_WORD) / 2;
                if (c >= FIRST_WORD && col >= BOUND_FIRST && col <= BOUND_LAST) begin
                    data <= 12'h800;
                end else begin
                    data <= 12'h000;
                end
            end else begin
                data <= word;
            end
            @(negedge clock);
            if (kind == CHK_PIXEL && c == len / 2) begin
                check_value(32'({red, green, blue}), 32'(exp_rgb), "pixel rgb");
                // visible position trails the driven word by two clocks
                if (exp_y >= 0) begin
                    check_value(32'(counter_x), 32'((c - FIRST_WORD) / 2), "counter_x");
                    check_value(32'(counter_y), 32'(exp_y), "counter_y");
                end
            end else if (kind == CHK_BARS) begin
                cx = int'(counter_x);
                pos = (cx - BAR_OFFSET) % BAR_WIDTH;
                if (cx >= BAR_OFFSET && cx < BAR_OFFSET + 8 * BAR_WIDTH &&
                    pos >= 2 && pos <= BAR_WIDTH - 3) begin
                    check_value(32'({red, green, blue}),
                                32'(bar_color((cx - BAR_OFFSET) / BAR_WIDTH)), "bar rgb");
                end
            end
        end
    endtask

    task automatic send_frame(input int r, input int f);
        logic [11:0] word;
        logic [23:0] exp_rgb;
        int          kind;
        int          exp_y;
        bit          in_win;
        for (int ln = 0; ln < rows[r].lines; ln++) begin
            word = 12'h000;
            kind = CHK_NONE;
            exp_rgb = 24'h0;
            exp_y = -1;
            in_win = (ln >= VGA_VSTART) && (ln < VGA_VSTART + VGA_HEIGHT);
            if (rows[r].pattern == PAT_PIXEL) begin
                word = 12'($urandom & 32'hFFF);
                // an all-ones word would look like an idle port
                if (word == 12'hFFF) begin
                    word = 12'hFFE;
                end
                if (in_win || f >= 1) begin
                    kind = CHK_PIXEL;
                    exp_rgb = in_win ? split_word(word) : 24'h0;
                    exp_y = in_win ? ln - VGA_VSTART : -1;
                end
            end else if (rows[r].pattern == PAT_DIAG) begin
                word = diag_words[ln % 8];
            end else if (rows[r].pattern == PAT_BARS) begin
                if (ln > VGA_VSTART && ln < VGA_VSTART + VGA_HEIGHT - 1) begin
                    kind = CHK_BARS;
                end
            end
            drive_line(rows[r].len, ln == 0, word, kind, exp_rgb, exp_y,
                       rows[r].pattern == PAT_BOUNDS && ln == BOUND_LINE);
        end
    endtask

    task automatic pulse_nonblack_reset();
        @(posedge clock);
        nonblack_reset <= 1'b1;
        @(posedge clock);
        nonblack_reset <= 1'b0;
        repeat (2) @(posedge clock);
    endtask

    initial begin
        logic [10:0] exp_10;
        logic [10:0] exp_01;
        logic [23:0] exp_color;
        int          clocks;

        void'($urandom(32'h9060));
        clock = 1'b0;
        reset = 1'b1;
        data = 12'h000;
        hsync_n = 1'b1;
        vsync_n = 1'b1;
        line_doubler = 1'b0;
        generate_video = 1'b0;
        generate_timing = 1'b0;
        nonblack_reset = 1'b0;
        errors = 0;
        checks = 0;

        rows[0] = '{263, 40, 1'b0, 1'b0, PAT_ZERO, 2, mode_240p, 1'b0};
        rows[1] = '{313, 40, 1'b0, 1'b0, PAT_ZERO, 2, mode_288p, 1'b0};
        rows[2] = '{525, 40, 1'b0, 1'b0, PAT_ZERO, 2, mode_480i, 1'b0};
        rows[3] = '{625, 40, 1'b0, 1'b0, PAT_ZERO, 2, mode_576i, 1'b0};
        rows[4] = '{400, 40, 1'b0, 1'b0, PAT_ZERO, 2, mode_vga, 1'b1};
        rows[5] = '{525, 1716, 1'b0, 1'b0, PAT_PIXEL, 2, mode_480i, 1'b0};
        rows[6] = '{525, 1716, 1'b0, 1'b1, PAT_BARS, 1, mode_480i, 1'b0};
        rows[7] = '{525, 1716, 1'b0, 1'b0, PAT_DIAG, 2, mode_480i, 1'b0};
        rows[8] = '{525, 1716, 1'b0, 1'b0, PAT_BOUNDS, 1, mode_480i, 1'b0};

        diag_words = '{12'h5A5, 12'hA5A, 12'h3C3, 12'hC3C,
                       12'h001, 12'h800, 12'h0F0, 12'h123};

        // table frames plus two generated frames, with margin
        limit = 2 * GEN_WIDTH * GEN_HEIGHT + 1000;
        for (int r = 0; r < ROWS; r++) begin
            limit += rows[r].lines * rows[r].len * rows[r].frames + 100;
        end
        limit += limit / 4;

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        for (int r = 0; r < ROWS; r++) begin
            @(posedge clock);
            line_doubler <= rows[r].doubler;
            generate_video <= rows[r].gen_video;
            if (rows[r].pattern == PAT_BOUNDS) begin
                pulse_nonblack_reset();
            end
            for (int f = 0; f < rows[r].frames; f++) begin
                send_frame(r, f);
            end
            // closing vsync classifies the last frame
            drive_line(8, 1'b1, 12'h000, CHK_NONE, 24'h0, -1, 1'b0);
            check_value(32'(mode), 32'(rows[r].exp_mode), "mode");
            check_value(32'(resync), 32'(rows[r].exp_resync), "resync");
            generate_video <= 1'b0;

            if (rows[r].pattern == PAT_DIAG) begin
                exp_10 = '0;
                exp_01 = '0;
                exp_color = '0;
                for (int w = 0; w < 8; w++) begin
                    for (int i = 0; i < 11; i++) begin
                        exp_10[i] = exp_10[i] | (diag_words[w][i+1] & !diag_words[w][i]);
                        exp_01[i] = exp_01[i] | (!diag_words[w][i+1] & diag_words[w][i]);
                    end
                    exp_color = exp_color | split_word(diag_words[w]);
                end
                check_value(32'(pin_ok), 32'({2'b00, exp_01, exp_10}), "pin_ok");
                check_value(32'(color_explorer), 32'(exp_color), "color_explorer");
            end
            if (rows[r].pattern == PAT_BOUNDS) begin
                check_value(32'(non_black_first), BOUND_FIRST, "non_black_first");
                check_value(32'(non_black_last), BOUND_LAST, "non_black_last");
                pulse_nonblack_reset();
                @(negedge clock);
                check_value(32'(non_black_first), 32'd4095, "cleared non_black_first");
                check_value(32'(non_black_last), 32'd0, "cleared non_black_last");
            end
        end

        ////////////////////////////////
        // idle port fallback
        ////////////////////////////////
        @(posedge clock);
        data <= 12'hFFF;
        hsync_n <= 1'b1;
        vsync_n <= 1'b1;
        clocks = 0;
        while (clocks < 210) begin
            @(posedge clock);
            clocks++;
            @(negedge clock);
            if (force_generate) begin
                break;
            end
        end
        check_value(32'(clocks >= IDLE_CLOCKS && clocks <= IDLE_CLOCKS + 2), 32'd1,
                    "force_generate rise in window");
        repeat (2 * GEN_WIDTH * GEN_HEIGHT + 10) @(posedge clock);
        @(negedge clock);
        check_value(32'(timing_info), 32'({12'd1716, 12'd525}), "timing_info");
        check_value(32'(resync), 32'd0, "generated resync");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_top #(
    parameter int IDLE_LIMIT = 108_000_000
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [capture_pkg::BUS_BITS-1:0]   data,
    input  logic                               hsync_n,
    input  logic                               vsync_n,
    input  logic                               line_doubler,
    input  logic                               generate_video,
    input  logic                               generate_timing,
    input  logic                               nonblack_reset,
    output logic [capture_pkg::COLOR_BITS-1:0] red,
    output logic [capture_pkg::COLOR_BITS-1:0] green,
    output logic [capture_pkg::COLOR_BITS-1:0] blue,
    output logic [capture_pkg::COUNT_BITS-1:0] counter_x,
    output logic [capture_pkg::COUNT_BITS-1:0] counter_y,
    output capture_pkg::video_mode_t           mode,
    output logic                               resync,
    output logic [23:0]                        timing_info,
    output logic [23:0]                        pin_ok,
    output logic [23:0]                        color_explorer,
    output logic [capture_pkg::COUNT_BITS-1:0] non_black_first,
    output logic [capture_pkg::COUNT_BITS-1:0] non_black_last,
    output logic                               force_generate
);
    import capture_pkg::*;

    logic                  generating;
    logic [COUNT_BITS-1:0] raw_x;
    logic [COUNT_BITS-1:0] raw_y;
    logic                  in_window;
    logic                  pixel_phase;
    logic                  frame_start;
    logic                  line_end;
    logic                  show_bars;
    logic [COLOR_BITS-1:0] bar_red;
    logic [COLOR_BITS-1:0] bar_green;
    logic [COLOR_BITS-1:0] bar_blue;

    assign show_bars = generate_video || force_generate;

    source_fsm #(
        .IDLE_LIMIT(IDLE_LIMIT)
    ) u_source_fsm (
        .clock(clock), .reset(reset), .data(data),
        .hsync_n(hsync_n), .vsync_n(vsync_n), .generate_timing(generate_timing),
        .generating(generating), .force_generate(force_generate)
    );

    raw_timing_counter u_raw_timing_counter (
        .clock(clock), .reset(reset), .generating(generating),
        .hsync_n(hsync_n), .vsync_n(vsync_n), .raw_x(raw_x), .raw_y(raw_y),
        .mode(mode), .resync(resync), .timing_info(timing_info)
    );

    window_mapper u_window_mapper (
        .clock(clock), .reset(reset), .raw_x(raw_x), .raw_y(raw_y),
        .mode(mode), .line_doubler(line_doubler),
        .counter_x(counter_x), .counter_y(counter_y), .in_window(in_window),
        .pixel_phase(pixel_phase), .frame_start(frame_start), .line_end(line_end)
    );

    bar_pattern u_bar_pattern (
        .clock(clock), .reset(reset), .counter_x(counter_x),
        .bar_red(bar_red), .bar_green(bar_green), .bar_blue(bar_blue)
    );

    pixel_assembler u_pixel_assembler (
        .clock(clock), .reset(reset), .data(data),
        .in_window(in_window), .pixel_phase(pixel_phase), .show_bars(show_bars),
        .bar_red(bar_red), .bar_green(bar_green), .bar_blue(bar_blue),
        .red(red), .green(green), .blue(blue)
    );

    frame_stats u_frame_stats (
        .clock(clock), .reset(reset), .data(data),
        .in_window(in_window), .pixel_phase(pixel_phase),
        .frame_start(frame_start), .line_end(line_end), .counter_x(counter_x),
        .red(red), .green(green), .blue(blue),
        .nonblack_reset(nonblack_reset), .show_bars(show_bars),
        .pin_ok(pin_ok), .color_explorer(color_explorer),
        .non_black_first(non_black_first), .non_black_last(non_black_last)
    );

endmodule

`default_nettype wire

// ==== frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [capture_pkg::BUS_BITS-1:0]   data,
    input  logic                               in_window,
    input  logic                               pixel_phase,
    input  logic                               frame_start,
    input  logic                               line_end,
    input  logic [capture_pkg::COUNT_BITS-1:0] counter_x,
    input  logic [capture_pkg::COLOR_BITS-1:0] red,
    input  logic [capture_pkg::COLOR_BITS-1:0] green,
    input  logic [capture_pkg::COLOR_BITS-1:0] blue,
    input  logic                               nonblack_reset,
    input  logic                               show_bars,
    output logic [23:0]                        pin_ok,
    output logic [23:0]                        color_explorer,
    output logic [capture_pkg::COUNT_BITS-1:0] non_black_first,
    output logic [capture_pkg::COUNT_BITS-1:0] non_black_last
);
    import capture_pkg::*;

    localparam int PAIRS = BUS_BITS - 1;

    logic [PAIRS-1:0]        pair_10;
    logic [PAIRS-1:0]        pair_01;
    logic [PAIRS-1:0]        seen_10;
    logic [PAIRS-1:0]        seen_01;
    logic [23:0]             rgb;
    logic [23:0]             color_acc;
    logic [COUNT_BITS-1:0]   x_q;
    logic [COUNT_BITS-1:0]   first_acc;
    logic [COUNT_BITS-1:0]   last_acc;

    assign rgb = {red, green, blue};

    // adjacent pins shorted together never show 10 or 01
    always_comb begin
        for (int i = 0; i < PAIRS; i++) begin
            pair_10[i] = data[i+1] && !data[i];
            pair_01[i] = !data[i+1] && data[i];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            seen_10         <= '0;
            seen_01         <= '0;
            color_acc       <= '0;
            pin_ok          <= '0;
            color_explorer  <= '0;
            x_q             <= '0;
            first_acc       <= '1;
            last_acc        <= '0;
            non_black_first <= '1;
            non_black_last  <= '0;
        end else begin
            x_q <= counter_x;

            if (frame_start) begin
                pin_ok         <= {{(24 - 2 * PAIRS){1'b0}}, seen_01, seen_10};
                color_explorer <= color_acc;
                seen_10        <= '0;
                seen_01        <= '0;
                color_acc      <= '0;
            end else if (!show_bars) begin
                if (in_window) begin
                    seen_10 <= seen_10 | pair_10;
                    seen_01 <= seen_01 | pair_01;
                end
                color_acc <= color_acc | rgb;
            end

            // rgb of column x_q is fresh on the first-word clock
            if (nonblack_reset) begin
                first_acc       <= '1;
                last_acc        <= '0;
                non_black_first <= '1;
                non_black_last  <= '0;
            end else if (line_end) begin
                non_black_first <= first_acc;
                non_black_last  <= last_acc;
            end else if (pixel_phase && rgb != '0) begin
                if (x_q < first_acc) begin
                    first_acc <= x_q;
                end
                if (x_q > last_acc) begin
                    last_acc <= x_q;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bar_pattern.sv ====
`timescale 1ns/1ps
`default_nettype none

module bar_pattern (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [capture_pkg::COUNT_BITS-1:0] counter_x,
    output logic [capture_pkg::COLOR_BITS-1:0] bar_red,
    output logic [capture_pkg::COLOR_BITS-1:0] bar_green,
    output logic [capture_pkg::COLOR_BITS-1:0] bar_blue
);
    import capture_pkg::*;

    // rgb lit mask, bar 0 first
    localparam logic [2:0] BAR_COLORS [8] = '{
        3'b100, 3'b010, 3'b001, 3'b111, 3'b000, 3'b011, 3'b110, 3'b101
    };

    logic [2:0] lit;

    always_comb begin
        lit = 3'b000;
        for (int i = 0; i < 8; i++) begin
            if (counter_x >= COUNT_BITS'(BAR_OFFSET + i * BAR_WIDTH)) begin
                lit = BAR_COLORS[i];
            end
        end
        if (counter_x >= COUNT_BITS'(BAR_OFFSET + 8 * BAR_WIDTH)) begin
            lit = 3'b000;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bar_red   <= '0;
            bar_green <= '0;
            bar_blue  <= '0;
        end else begin
            bar_red   <= {COLOR_BITS{lit[2]}};
            bar_green <= {COLOR_BITS{lit[1]}};
            bar_blue  <= {COLOR_BITS{lit[0]}};
        end
    end

endmodule

`default_nettype wire

// ==== pixel_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_assembler (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [capture_pkg::BUS_BITS-1:0]   data,
    input  logic                               in_window,
    input  logic                               pixel_phase,
    input  logic                               show_bars,
    input  logic [capture_pkg::COLOR_BITS-1:0] bar_red,
    input  logic [capture_pkg::COLOR_BITS-1:0] bar_green,
    input  logic [capture_pkg::COLOR_BITS-1:0] bar_blue,
    output logic [capture_pkg::COLOR_BITS-1:0] red,
    output logic [capture_pkg::COLOR_BITS-1:0] green,
    output logic [capture_pkg::COLOR_BITS-1:0] blue
);
    import capture_pkg::*;

    // green is split across the two words
    localparam int SPLIT = BUS_BITS - COLOR_BITS;

    logic [COLOR_BITS-1:0] red_hold;
    logic [SPLIT-1:0]      green_hold;

    // first word of a pair
    always_ff @(posedge clock) begin
        if (in_window && pixel_phase) begin
            red_hold   <= data[BUS_BITS-1 -: COLOR_BITS];
            green_hold <= data[SPLIT-1:0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (!in_window) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (show_bars) begin
            red   <= bar_red;
            green <= bar_green;
            blue  <= bar_blue;
        end else if (!pixel_phase) begin
            red   <= red_hold;
            green <= {green_hold, data[BUS_BITS-1 -: COLOR_BITS-SPLIT]};
            blue  <= data[COLOR_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== window_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_mapper (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [capture_pkg::COUNT_BITS-1:0] raw_x,
    input  logic [capture_pkg::COUNT_BITS-1:0] raw_y,
    input  capture_pkg::video_mode_t           mode,
    input  logic                               line_doubler,
    output logic [capture_pkg::COUNT_BITS-1:0] counter_x,
    output logic [capture_pkg::COUNT_BITS-1:0] counter_y,
    output logic                               in_window,
    output logic                               pixel_phase,
    output logic                               frame_start,
    output logic                               line_end
);
    import capture_pkg::*;

    window_t               win;
    logic                  at_hstart;
    logic                  at_vstart;
    logic [COUNT_BITS-1:0] x_next;
    logic [COUNT_BITS-1:0] y_next;

    always_comb begin
        win = WIN_VGA;
        if (line_doubler) begin
            case (mode)
                mode_480i: win = WIN_480I;
                mode_576i: win = WIN_576I;
                mode_240p: win = WIN_240P;
                mode_288p: win = WIN_288P;
                default:   win = WIN_VGA;
            endcase
        end
    end

    assign at_hstart = (raw_x == win.hstart);
    assign at_vstart = (raw_y == win.vstart);

    // visible x advances once per word pair
    always_comb begin
        x_next = counter_x + COUNT_BITS'(raw_x[0]);
        y_next = counter_y;
        if (at_hstart) begin
            x_next = '0;
            y_next = at_vstart ? '0 : counter_y + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counter_x   <= '0;
            counter_y   <= '1;
            in_window   <= 1'b0;
            pixel_phase <= 1'b0;
            frame_start <= 1'b0;
            line_end    <= 1'b0;
        end else begin
            counter_x   <= x_next;
            counter_y   <= y_next;
            in_window   <= (x_next < win.width) && (y_next < win.height);
            pixel_phase <= raw_x[0];
            frame_start <= at_hstart && at_vstart;
            line_end    <= (x_next == win.width - 1'b1) && !raw_x[0];
        end
    end

endmodule

`default_nettype wire

// ==== raw_timing_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module raw_timing_counter (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               generating,
    input  logic                               hsync_n,
    input  logic                               vsync_n,
    output logic [capture_pkg::COUNT_BITS-1:0] raw_x,
    output logic [capture_pkg::COUNT_BITS-1:0] raw_y,
    output capture_pkg::video_mode_t           mode,
    output logic                               resync,
    output logic [23:0]                        timing_info
);
    import capture_pkg::*;

    logic                  hsync_q;
    logic                  vsync_q;
    logic                  h_fall;
    logic                  v_fall;
    logic [COUNT_BITS-1:0] line_len;
    logic [COUNT_BITS-1:0] frame_lines;
    video_mode_t           mode_next;
    logic                  resync_next;

    assign h_fall      = hsync_q && !hsync_n;
    assign v_fall      = vsync_q && !vsync_n;
    assign timing_info = {line_len, frame_lines};

    // classify on the final line index of the frame
    always_comb begin
        mode_next   = mode_vga;
        resync_next = 1'b0;
        case (raw_y)
            COUNT_BITS'(LINES_240P): mode_next = mode_240p;
            COUNT_BITS'(LINES_288P): mode_next = mode_288p;
            COUNT_BITS'(LINES_480I): mode_next = mode_480i;
            COUNT_BITS'(LINES_576I): mode_next = mode_576i;
            default:                 resync_next = 1'b1;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hsync_q     <= 1'b1;
            vsync_q     <= 1'b1;
            raw_x       <= '0;
            raw_y       <= '0;
            line_len    <= '0;
            frame_lines <= '0;
            mode        <= mode_vga;
            resync      <= 1'b1;
        end else begin
            hsync_q <= hsync_n;
            vsync_q <= vsync_n;

            if (generating) begin
                if (raw_x >= COUNT_BITS'(GEN_WIDTH - 1)) begin
                    raw_x    <= '0;
                    line_len <= raw_x + 1'b1;
                    if (raw_y >= COUNT_BITS'(GEN_HEIGHT - 1)) begin
                        raw_y       <= '0;
                        frame_lines <= raw_y + 1'b1;
                        resync      <= 1'b0;
                    end else begin
                        raw_y <= raw_y + 1'b1;
                    end
                end else begin
                    raw_x <= raw_x + 1'b1;
                end
            end else if (h_fall) begin
                raw_x    <= '0;
                line_len <= raw_x + 1'b1;
                if (v_fall) begin
                    mode        <= mode_next;
                    resync      <= resync_next;
                    frame_lines <= raw_y + 1'b1;
                    raw_y       <= '0;
                end else begin
                    raw_y <= raw_y + 1'b1;
                end
            end else begin
                raw_x <= raw_x + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module source_fsm #(
    parameter int IDLE_LIMIT = 108_000_000
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [capture_pkg::BUS_BITS-1:0] data,
    input  logic                             hsync_n,
    input  logic                             vsync_n,
    input  logic                             generate_timing,
    output logic                             generating,
    output logic                             force_generate
);
    import capture_pkg::*;

    // one spare count so the counter cannot wrap on the entry clock
    localparam int IDLE_BITS = $clog2(IDLE_LIMIT + 2);
    localparam logic [IDLE_BITS-1:0] LIMIT_COUNT = IDLE_BITS'(IDLE_LIMIT);

    source_state_t        state;
    logic                 hsync_q;
    logic                 vsync_q;
    logic                 idle;
    logic                 enter_generate;
    logic [IDLE_BITS-1:0] idle_count;

    // port idle means every line sits high
    assign idle = hsync_q && hsync_n && vsync_q && vsync_n && (&data);
    assign enter_generate = (state == st_follow) && (idle_count == LIMIT_COUNT);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= st_follow;
            hsync_q        <= 1'b1;
            vsync_q        <= 1'b1;
            idle_count     <= '0;
            force_generate <= 1'b0;
            generating     <= 1'b0;
        end else begin
            hsync_q <= hsync_n;
            vsync_q <= vsync_n;

            case (state)
                st_follow: begin
                    if (idle) begin
                        idle_count <= idle_count + 1'b1;
                    end else begin
                        idle_count <= '0;
                    end
                    if (enter_generate) begin
                        state          <= st_generate;
                        force_generate <= 1'b1;
                    end
                end
                // left only through reset
                default: begin
                    state <= st_generate;
                end
            endcase

            generating <= generate_timing || (state == st_generate) || enter_generate;
        end
    end

endmodule

`default_nettype wire

// ==== capture_pkg.sv ====
`default_nettype none

package capture_pkg;

    localparam int BUS_BITS   = 12;
    localparam int COLOR_BITS = 8;
    localparam int COUNT_BITS = 12;

    // generated timing in raw clocks and lines
    localparam int GEN_WIDTH  = 1716;
    localparam int GEN_HEIGHT = 525;

    // final raw line index of each standard frame
    localparam int LINES_240P = 262;
    localparam int LINES_288P = 312;
    localparam int LINES_480I = 524;
    localparam int LINES_576I = 624;

    typedef enum logic [2:0] {
        mode_vga,
        mode_480i,
        mode_576i,
        mode_240p,
        mode_288p
    } video_mode_t;

    typedef enum logic {
        st_follow,
        st_generate
    } source_state_t;

    typedef struct packed {
        logic [COUNT_BITS-1:0] hstart;
        logic [COUNT_BITS-1:0] vstart;
        logic [COUNT_BITS-1:0] width;
        logic [COUNT_BITS-1:0] height;
    } window_t;

    ////////////////////////////////
    // visible window per mode
    ////////////////////////////////
    localparam window_t WIN_VGA  = '{12'd265, 12'd40, 12'd720, 12'd480};
    localparam window_t WIN_480I = '{12'd257, 12'd18, 12'd720, 12'd504};
    localparam window_t WIN_576I = '{12'd279, 12'd22, 12'd720, 12'd600};
    localparam window_t WIN_240P = '{12'd257, 12'd18, 12'd720, 12'd504};
    localparam window_t WIN_288P = '{12'd257, 12'd24, 12'd720, 12'd600};

    // colour bars
    localparam int BAR_OFFSET = 52;
    localparam int BAR_WIDTH  = 80;

endpackage

`default_nettype wire
